//--- Makefile
SIM = obj_dir/Vtb_stream_top

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(SIM): tb.f logic/*.sv test/*.sv
	verilator --binary --timing --assert --top-module tb_stream_top -f tb.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^Result: PASSED$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/stream_pkg.sv
package stream_pkg;

   // --------------------------------------------------
   // Sample word and buffer geometry
   // --------------------------------------------------

   // One capture sample per buffer word
   localparam int DATA_W = 24;

   // Width of a buffer address
   localparam int ADDR_W = 6;

   // Buffer depth follows from the address width
   localparam int WORDS = 1 << ADDR_W;

   // --------------------------------------------------
   // Address sequence shared by both stream adapters
   // --------------------------------------------------

   // First address after reset and after every wrap
   localparam logic [ADDR_W-1:0] START_ADR = '0;

   // Increment applied on each accepted beat
   localparam logic [ADDR_W-1:0] STEP_ADR = ADDR_W'(1);

   // Final address of the sequence
   // The counter returns to START_ADR on the beat after this one
   localparam logic [ADDR_W-1:0] LAST_ADR = ADDR_W'(int'(START_ADR) + WORDS - 1);

endpackage

//--- logic/stream_top.sv
module stream_top
   import stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,

   // Capture stream
   input  logic              cap_cyc_i,
   input  logic              cap_stb_i,
   input  logic              cap_we_i,
   input  logic [DATA_W-1:0] cap_dat_i,
   output logic              cap_ack_o,
   output logic              cap_wat_o,
   output logic [DATA_W-1:0] cap_dat_o,
   output logic              cap_wrapped_o,

   // Readout stream
   input  logic              rd_cyc_i,
   input  logic              rd_stb_i,
   input  logic              rd_we_i,
   input  logic [DATA_W-1:0] rd_dat_i,
   output logic              rd_ack_o,
   output logic              rd_wat_o,
   output logic [DATA_W-1:0] rd_dat_o,
   output logic              rd_wrapped_o
);

   // --------------------------------------------------
   // Interconnect
   // --------------------------------------------------

   // Capture adapter to arbiter
   logic              cap_m_cyc;
   logic              cap_m_stb;
   logic              cap_m_we;
   logic [ADDR_W-1:0] cap_m_adr;
   logic [DATA_W-1:0] cap_m_wdat;
   logic              cap_m_ack;
   logic              cap_m_wat;
   logic [DATA_W-1:0] cap_m_rdat;

   // Readout adapter to arbiter
   logic              rd_m_cyc;
   logic              rd_m_stb;
   logic              rd_m_we;
   logic [ADDR_W-1:0] rd_m_adr;
   logic [DATA_W-1:0] rd_m_wdat;
   logic              rd_m_ack;
   logic              rd_m_wat;
   logic [DATA_W-1:0] rd_m_rdat;

   // Arbiter to memory
   logic              mem_stb;
   logic              mem_we;
   logic [ADDR_W-1:0] mem_adr;
   logic [DATA_W-1:0] mem_wdat;
   logic              mem_ack;
   logic [DATA_W-1:0] mem_rdat;

   // --------------------------------------------------
   // Stream adapters
   // --------------------------------------------------

   wb_stream cap_stream_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .s_cyc_i   (cap_cyc_i),
      .s_stb_i   (cap_stb_i),
      .s_we_i    (cap_we_i),
      .s_dat_i   (cap_dat_i),
      .s_ack_o   (cap_ack_o),
      .s_wat_o   (cap_wat_o),
      .s_dat_o   (cap_dat_o),
      .m_cyc_o   (cap_m_cyc),
      .m_stb_o   (cap_m_stb),
      .m_we_o    (cap_m_we),
      .m_adr_o   (cap_m_adr),
      .m_dat_o   (cap_m_wdat),
      .m_ack_i   (cap_m_ack),
      .m_wat_i   (cap_m_wat),
      .m_dat_i   (cap_m_rdat),
      .wrapped_o (cap_wrapped_o)
   );

   wb_stream rd_stream_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .s_cyc_i   (rd_cyc_i),
      .s_stb_i   (rd_stb_i),
      .s_we_i    (rd_we_i),
      .s_dat_i   (rd_dat_i),
      .s_ack_o   (rd_ack_o),
      .s_wat_o   (rd_wat_o),
      .s_dat_o   (rd_dat_o),
      .m_cyc_o   (rd_m_cyc),
      .m_stb_o   (rd_m_stb),
      .m_we_o    (rd_m_we),
      .m_adr_o   (rd_m_adr),
      .m_dat_o   (rd_m_wdat),
      .m_ack_i   (rd_m_ack),
      .m_wat_i   (rd_m_wat),
      .m_dat_i   (rd_m_rdat),
      .wrapped_o (rd_wrapped_o)
   );

   // --------------------------------------------------
   // Shared memory port
   // --------------------------------------------------

   // Capture is master a and gets the first contested turn
   wb_arbiter arb_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .a_cyc_i (cap_m_cyc),
      .a_stb_i (cap_m_stb),
      .a_we_i  (cap_m_we),
      .a_adr_i (cap_m_adr),
      .a_dat_i (cap_m_wdat),
      .a_ack_o (cap_m_ack),
      .a_wat_o (cap_m_wat),
      .a_dat_o (cap_m_rdat),
      .b_cyc_i (rd_m_cyc),
      .b_stb_i (rd_m_stb),
      .b_we_i  (rd_m_we),
      .b_adr_i (rd_m_adr),
      .b_dat_i (rd_m_wdat),
      .b_ack_o (rd_m_ack),
      .b_wat_o (rd_m_wat),
      .b_dat_o (rd_m_rdat),
      .m_stb_o (mem_stb),
      .m_we_o  (mem_we),
      .m_adr_o (mem_adr),
      .m_dat_o (mem_wdat),
      .m_ack_i (mem_ack),
      .m_dat_i (mem_rdat)
   );

   wb_sram sram_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .stb_i (mem_stb),
      .we_i  (mem_we),
      .adr_i (mem_adr),
      .dat_i (mem_wdat),
      .ack_o (mem_ack),
      .dat_o (mem_rdat)
   );

endmodule

//--- logic/wb_arbiter.sv
module wb_arbiter
   import stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,

   // Master a, the capture stream
   input  logic              a_cyc_i,
   input  logic              a_stb_i,
   input  logic              a_we_i,
   input  logic [ADDR_W-1:0] a_adr_i,
   input  logic [DATA_W-1:0] a_dat_i,
   output logic              a_ack_o,
   output logic              a_wat_o,
   output logic [DATA_W-1:0] a_dat_o,

   // Master b, the readout stream
   input  logic              b_cyc_i,
   input  logic              b_stb_i,
   input  logic              b_we_i,
   input  logic [ADDR_W-1:0] b_adr_i,
   input  logic [DATA_W-1:0] b_dat_i,
   output logic              b_ack_o,
   output logic              b_wat_o,
   output logic [DATA_W-1:0] b_dat_o,

   // Single memory port
   output logic              m_stb_o,
   output logic              m_we_o,
   output logic [ADDR_W-1:0] m_adr_o,
   output logic [DATA_W-1:0] m_dat_o,
   input  logic              m_ack_i,
   input  logic [DATA_W-1:0] m_dat_i
);

   logic a_req;
   logic b_req;
   logic contest;
   logic grant_a;
   logic grant_b;
   // High when master b has priority on the next contested cycle
   logic turn_b_q;
   // High when the beat now being acknowledged belonged to b
   logic owner_b_q;

   // --------------------------------------------------
   // Grant decision
   // --------------------------------------------------

   assign a_req   = a_cyc_i && a_stb_i;
   assign b_req   = b_cyc_i && b_stb_i;
   assign contest = a_req && b_req;

   // A lone requester always wins
   // Under contest the turn register picks the winner
   assign grant_b = b_req && (!a_req || turn_b_q);
   assign grant_a = a_req && !grant_b;

   // The loser sees wait and holds its beat
   assign a_wat_o = grant_b;
   assign b_wat_o = grant_a;

   // --------------------------------------------------
   // Forward path to the memory
   // --------------------------------------------------

   // Memory never stalls, so a strobe here is an accepted beat
   assign m_stb_o = grant_a || grant_b;
   assign m_we_o  = grant_b ? b_we_i  : a_we_i;
   assign m_adr_o = grant_b ? b_adr_i : a_adr_i;
   assign m_dat_o = grant_b ? b_dat_i : a_dat_i;

   // Alternate after every contested beat
   // Capture side goes first out of reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         turn_b_q <= 1'b0;
      end else if (contest) begin
         turn_b_q <= !turn_b_q;
      end
   end

   // --------------------------------------------------
   // Return path
   // --------------------------------------------------

   // Remember who owns the beat taken this cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         owner_b_q <= 1'b0;
      end else if (m_stb_o) begin
         owner_b_q <= grant_b;
      end
   end

   // Ack and read data reach only the owning master
   assign a_ack_o = m_ack_i && !owner_b_q;
   assign b_ack_o = m_ack_i && owner_b_q;
   assign a_dat_o = owner_b_q ? '0 : m_dat_i;
   assign b_dat_o = owner_b_q ? m_dat_i : '0;

endmodule

//--- logic/wb_sram.sv
module wb_sram
   import stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,

   // Access request, already arbitrated
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] adr_i,
   input  logic [DATA_W-1:0] dat_i,

   // Response one cycle after the access
   output logic              ack_o,
   output logic [DATA_W-1:0] dat_o
);

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------

   // Sample buffer, one word per address
   logic [DATA_W-1:0] mem [WORDS];

   // Registered read word
   logic [DATA_W-1:0] rd_q;

   // Registered acknowledge
   logic              ack_q;

   // Block RAM style port
   // Writes land on the accept edge
   // Reads capture the addressed word on the same edge
   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         if (we_i) begin
            mem[adr_i] <= dat_i;
         end else begin
            rd_q <= mem[adr_i];
         end
      end
   end

   // --------------------------------------------------
   // Acknowledge
   // --------------------------------------------------

   // Every strobe is a taken beat, so ack follows it directly
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i;
      end
   end

   assign ack_o = ack_q;

   // Read word is valid in the ack cycle
   // After a write it still holds the last read
   assign dat_o = rd_q;

endmodule

//--- logic/wb_stream.sv
module wb_stream
   import stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,

   // Stream side, the requester never supplies an address
   input  logic              s_cyc_i,
   input  logic              s_stb_i,
   input  logic              s_we_i,
   input  logic [DATA_W-1:0] s_dat_i,
   output logic              s_ack_o,
   output logic              s_wat_o,
   output logic [DATA_W-1:0] s_dat_o,

   // Addressed side towards the arbiter
   output logic              m_cyc_o,
   output logic              m_stb_o,
   output logic              m_we_o,
   output logic [ADDR_W-1:0] m_adr_o,
   output logic [DATA_W-1:0] m_dat_o,
   input  logic              m_ack_i,
   input  logic              m_wat_i,
   input  logic [DATA_W-1:0] m_dat_i,

   // High for one cycle after the beat at LAST_ADR
   output logic              wrapped_o
);

   logic              accept;
   logic              at_last;
   logic [ADDR_W-1:0] adr_q;
   logic [ADDR_W-1:0] adr_next;
   logic              wrapped_q;

   // --------------------------------------------------
   // Bus pass-through
   // --------------------------------------------------

   // Requests go downstream unchanged
   assign m_cyc_o = s_cyc_i;
   assign m_stb_o = s_stb_i;
   assign m_we_o  = s_we_i;
   assign m_dat_o = s_dat_i;

   // Responses come back unchanged, zero cycles
   assign s_ack_o = m_ack_i;
   assign s_wat_o = m_wat_i;
   assign s_dat_o = m_dat_i;

   // --------------------------------------------------
   // Address generation
   // --------------------------------------------------

   // Pipelined acceptance, wait low while cycle and strobe are up
   assign accept = s_cyc_i && s_stb_i && !m_wat_i;

   // Current beat sits on the final address
   assign at_last = (adr_q == LAST_ADR);

   // Step forward or fold back to the start
   assign adr_next = at_last ? START_ADR : adr_q + STEP_ADR;

   // The held count addresses the beat now on the bus
   assign m_adr_o = adr_q;

   // Counter moves only when the beat is taken
   // A stalled beat keeps its address
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q <= START_ADR;
      end else if (accept) begin
         adr_q <= adr_next;
      end
   end

   // One-cycle pulse after the last address has been used
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrapped_q <= 1'b0;
      end else begin
         wrapped_q <= accept && at_last;
      end
   end

   assign wrapped_o = wrapped_q;

endmodule

//--- tb.f
logic/stream_pkg.sv
logic/wb_stream.sv
logic/wb_arbiter.sv
logic/wb_sram.sv
logic/stream_top.sv
test/tb_stream_top.sv

//--- test/tb_stream_top.sv
module tb_stream_top
   import stream_pkg::*;
();

   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 8;
   localparam int SEED          = 32'h7278_43dc;
   localparam int EXTRA_BEATS   = 6;
   localparam int CONTEND_BEATS = 150;
   localparam int MAX_BEATS     = 150;
   localparam int IDLE_CYCLES   = 10;
   // Every beat of both sides across all phases
   localparam int TOTAL_BEATS   = 2 * (WORDS + EXTRA_BEATS + CONTEND_BEATS + 1);
   localparam int MARGIN        = 8;

   logic              clk = 1'b0;
   logic              rst;
   logic              cap_cyc, cap_stb, cap_we, rd_cyc, rd_stb, rd_we;
   logic [DATA_W-1:0] cap_dat, rd_dat;
   logic              cap_ack_o, cap_wat_o, cap_wrapped_o;
   logic              rd_ack_o, rd_wat_o, rd_wrapped_o;
   logic [DATA_W-1:0] cap_dat_o, rd_dat_o;

   // Reference model state
   logic [DATA_W-1:0] model_mem [WORDS];
   logic [ADDR_W-1:0] cap_exp_adr, rd_exp_adr;
   logic [DATA_W-1:0] cap_exp_dat, rd_exp_dat;
   logic              cap_acc_q, rd_acc_q, cap_wrap_q, rd_wrap_q;
   // High in the ack cycle of a capture read beat
   logic              cap_rd_q;
   // High when readout wins the next contested cycle
   logic              turn_rd;
   logic              cap_req, rd_req, cap_acc, rd_acc;
   int                cap_sent = 0;
   int                rd_sent = 0;
   int                cap_acks = 0;
   int                rd_acks = 0;

   // Stimulus prepared ahead of each phase
   logic [DATA_W-1:0] cap_words [MAX_BEATS];
   int                cap_gaps [MAX_BEATS];
   int                rd_gaps [MAX_BEATS];

   always #(CLK_PERIOD / 2) clk = !clk;

   stream_top dut_i (
      .clk_i (clk), .rst_i (rst),
      .cap_cyc_i (cap_cyc), .cap_stb_i (cap_stb), .cap_we_i (cap_we), .cap_dat_i (cap_dat),
      .cap_ack_o (cap_ack_o), .cap_wat_o (cap_wat_o), .cap_dat_o (cap_dat_o),
      .cap_wrapped_o (cap_wrapped_o),
      .rd_cyc_i (rd_cyc), .rd_stb_i (rd_stb), .rd_we_i (rd_we), .rd_dat_i (rd_dat),
      .rd_ack_o (rd_ack_o), .rd_wat_o (rd_wat_o), .rd_dat_o (rd_dat_o),
      .rd_wrapped_o (rd_wrapped_o)
   );

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // Acceptance as seen at the ports
   assign cap_req = cap_cyc && cap_stb;
   assign rd_req  = rd_cyc && rd_stb;
   assign cap_acc = cap_req && !cap_wat_o;
   assign rd_acc  = rd_req && !rd_wat_o;

   // Counter rule, step forward and fold back after the last address
   function automatic logic [ADDR_W-1:0] next_adr(input logic [ADDR_W-1:0] adr);
      if (adr == LAST_ADR) begin
         return START_ADR;
      end
      return adr + STEP_ADR;
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         cap_exp_adr <= START_ADR;
         rd_exp_adr  <= START_ADR;
         cap_acc_q   <= 1'b0;
         rd_acc_q    <= 1'b0;
         cap_wrap_q  <= 1'b0;
         rd_wrap_q   <= 1'b0;
         cap_rd_q    <= 1'b0;
         turn_rd     <= 1'b0;
      end else begin
         cap_acc_q  <= cap_acc;
         rd_acc_q   <= rd_acc;
         cap_wrap_q <= cap_acc && (cap_exp_adr == LAST_ADR);
         rd_wrap_q  <= rd_acc && (rd_exp_adr == LAST_ADR);
         cap_rd_q   <= cap_acc && !cap_we;
         if (cap_acc) begin
            cap_exp_adr <= next_adr(cap_exp_adr);
            if (cap_we) begin
               model_mem[cap_exp_adr] <= cap_dat;
            end else begin
               cap_exp_dat <= model_mem[cap_exp_adr];
            end
         end
         if (rd_acc) begin
            rd_exp_adr <= next_adr(rd_exp_adr);
            rd_exp_dat <= model_mem[rd_exp_adr];
         end
         // Turn flips on every contested beat
         if (cap_req && rd_req) begin
            turn_rd <= !turn_rd;
         end
         if (cap_ack_o) begin
            cap_acks <= cap_acks + 1;
         end
         if (rd_ack_o) begin
            rd_acks <= rd_acks + 1;
         end
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------

   task automatic stop_failed();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("** Error: %s expected %0h actual %0h", name, expected, actual);
      stop_failed();
   endtask

   // Ack exactly one cycle after an accepted beat, on that side only
   assert property (@(posedge clk) disable iff (rst) cap_ack_o == cap_acc_q)
      else report_mismatch("ack_cap", 32'(cap_acc_q), 32'(cap_ack_o));
   assert property (@(posedge clk) disable iff (rst) rd_ack_o == rd_acc_q)
      else report_mismatch("ack_rd", 32'(rd_acc_q), 32'(rd_ack_o));

   // Wrapped pulse only in the cycle after the LAST_ADR beat
   assert property (@(posedge clk) disable iff (rst) cap_wrapped_o == cap_wrap_q)
      else report_mismatch("wrapped_cap", 32'(cap_wrap_q), 32'(cap_wrapped_o));
   assert property (@(posedge clk) disable iff (rst) rd_wrapped_o == rd_wrap_q)
      else report_mismatch("wrapped_rd", 32'(rd_wrap_q), 32'(rd_wrapped_o));

   // Read word matches the model at the expected readout address
   assert property (@(posedge clk) disable iff (rst) rd_ack_o |-> rd_dat_o == rd_exp_dat)
      else report_mismatch("read_data", 32'(rd_exp_dat), 32'(rd_dat_o));

   // Capture read word matches the model at the expected capture address
   assert property (@(posedge clk) disable iff (rst)
                    (cap_ack_o && cap_rd_q) |-> cap_dat_o == cap_exp_dat)
      else report_mismatch("read_data_cap", 32'(cap_exp_dat), 32'(cap_dat_o));

   // Exactly one loser under contest, sides served in turn
   assert property (@(posedge clk) disable iff (rst)
                    (cap_req && rd_req) |-> ({cap_wat_o, rd_wat_o} == {turn_rd, !turn_rd}))
      else report_mismatch("grant_contest", 32'({turn_rd, !turn_rd}),
                           32'({cap_wat_o, rd_wat_o}));

   // A lone requester never waits
   assert property (@(posedge clk) disable iff (rst) (cap_req && !rd_req) |-> !cap_wat_o)
      else report_mismatch("grant_lone_cap", 32'(0), 32'(cap_wat_o));
   assert property (@(posedge clk) disable iff (rst) (rd_req && !cap_req) |-> !rd_wat_o)
      else report_mismatch("grant_lone_rd", 32'(0), 32'(rd_wat_o));

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------

   task automatic prepare_stimulus(input int count, input bit with_gaps);
      for (int i = 0; i < count; i++) begin
         cap_words[i] = DATA_W'($urandom);
         cap_gaps[i]  = with_gaps ? int'($urandom_range(2, 0)) : 0;
         rd_gaps[i]   = with_gaps ? int'($urandom_range(3, 0)) : 0;
      end
   endtask

   // Called on a falling edge, holds each beat until accepted
   task automatic capture_beats(input int count);
      for (int i = 0; i < count; i++) begin
         repeat (cap_gaps[i]) begin
            cap_stb = 1'b0;
            @(negedge clk);
         end
         cap_stb = 1'b1;
         cap_dat = cap_words[i];
         cap_sent++;
         @(negedge clk);
         while (!cap_acc_q) begin
            @(negedge clk);
         end
      end
      cap_stb = 1'b0;
   endtask

   task automatic read_beats(input int count);
      for (int i = 0; i < count; i++) begin
         repeat (rd_gaps[i]) begin
            rd_stb = 1'b0;
            @(negedge clk);
         end
         rd_stb = 1'b1;
         rd_sent++;
         @(negedge clk);
         while (!rd_acc_q) begin
            @(negedge clk);
         end
      end
      rd_stb = 1'b0;
   endtask

   // Watchdog
   initial begin
      #(TOTAL_BEATS * MARGIN * CLK_PERIOD);
      $display("Watchdog expired before all beats completed");
      stop_failed();
   end

   initial begin
      void'($urandom(SEED));
      rst     = 1'b1;
      cap_cyc = 1'b0;
      cap_stb = 1'b0;
      cap_we  = 1'b1;
      cap_dat = '0;
      rd_cyc  = 1'b0;
      rd_stb  = 1'b0;
      rd_we   = 1'b0;
      rd_dat  = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst     = 1'b0;
      cap_cyc = 1'b1;
      rd_cyc  = 1'b1;

      // Fill the whole buffer, then read it back
      prepare_stimulus(WORDS, 1'b0);
      capture_beats(WORDS);
      read_beats(WORDS);

      // Words past LAST_ADR overwrite the first entries
      prepare_stimulus(EXTRA_BEATS, 1'b1);
      capture_beats(EXTRA_BEATS);
      read_beats(EXTRA_BEATS);

      // Strobes low, nothing may move
      repeat (IDLE_CYCLES) @(negedge clk);

      // Both streams compete for the memory
      prepare_stimulus(CONTEND_BEATS, 1'b1);
      fork
         capture_beats(CONTEND_BEATS);
         read_beats(CONTEND_BEATS);
      join

      // Mid-run reset, next read on either side comes from entry 0
      repeat (3) @(negedge clk);
      rst = 1'b1;
      repeat (3) @(negedge clk);
      rst    = 1'b0;
      cap_we = 1'b0;
      fork
         capture_beats(1);
         read_beats(1);
      join
      repeat (3) @(negedge clk);

      if (cap_acks != cap_sent) begin
         report_mismatch("beat_count_cap", 32'(cap_sent), 32'(cap_acks));
      end else if (rd_acks != rd_sent) begin
         report_mismatch("beat_count_rd", 32'(rd_sent), 32'(rd_acks));
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule
